//--- compile.f
defines.sv
exec_if.sv
core_ctrl.sv
pc_reg.sv
regfile.sv
execute.sv
wb.sv
core_top.sv
tb_core.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - defines.sv
  - exec_if.sv
  - core_ctrl.sv
  - pc_reg.sv
  - regfile.sv
  - execute.sv
  - wb.sv
  - core_top.sv
  - target: simulation
    files:
      - tb_core.sv

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core import defines::*; ();

	localparam data_t       RESET_PC    = 32'h0000_0080;
	localparam int          NUM_RETIRES = 400;
	localparam int          MAX_CYCLES  = NUM_RETIRES * 4 + 100;
	localparam logic [31:0] SEED        = 32'hef76d142;

	logic     clk;
	logic     arst_n;
	data_t    instr_addr;
	data_t    instr_rdata;
	data_t    data_addr;
	data_t    data_wdata;
	data_t    data_rdata;
	logic     data_we;
	logic     data_re;
	logic     retire;
	data_t    retire_pc;
	data_t    retire_data;
	reg_idx_t retire_rd;

	data_t       imem [256];
	data_t       dmem [64];   // Data memory behind the DUT's port.
	data_t       m_dmem [64]; // The reference model keeps its own copy.
	data_t       m_regs [32];
	data_t       m_pc;
	logic [31:0] lfsr;
	int          cycle_count = 0;
	int          last_retire = 0;
	int          retired = 0;
	logic        store_seen;
	logic        load_seen;
	data_t       st_addr;
	data_t       st_data;

	core_top #(.RESET_PC(RESET_PC)) i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_addr  (instr_addr),
		.instr_rdata (instr_rdata),
		.data_addr   (data_addr),
		.data_wdata  (data_wdata),
		.data_rdata  (data_rdata),
		.data_we     (data_we),
		.data_re     (data_re),
		.retire      (retire),
		.retire_pc   (retire_pc),
		.retire_data (retire_data),
		.retire_rd   (retire_rd)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois LFSR stepped once for every bit it hands out.
	function automatic data_t rand_bits(input int n);
		data_t r;
		logic  b;
		r = '0;
		for (int k = 0; k < n; k++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ 32'h8020_0003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic data_t gen_instr();
		data_t      imm;
		data_t      up;
		logic [3:0] sel;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		logic [2:0] f3;
		data_t      ins;
		sel = 4'(rand_bits(4));
		rd  = 5'(rand_bits(5));
		rs1 = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		f3  = 3'(rand_bits(3));
		imm = rand_bits(12);
		up  = rand_bits(20);
		case (sel)
			0, 1, 2: begin
				if (f3 == 3'b001) imm[11:5] = 7'b0; // SLLI takes a plain shift amount.
				else if (f3 == 3'b101) imm[11:5] = {1'b0, imm[10], 5'b0};
				ins = {imm[11:0], rs1, f3, rd, 7'b0010011};
			end
			3, 4: ins = {1'b0, imm[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
					rs2, rs1, f3, rd, 7'b0110011};
			5: ins = {up[19:0], rd, 7'b0110111};
			6: ins = {up[19:0], rd, 7'b0010111};
			7, 8: ins = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
			9, 10: ins = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
			11, 12: begin
				if (f3[2:1] == 2'b01) f3[1] = 1'b0; // 010 and 011 are not branches.
				ins = {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], 7'b1100011};
			end
			13: ins = {up[19], up[9:0], up[10], up[18:11], rd, 7'b1101111};
			14: ins = {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
			default: ins = imm[0] ? 32'h0ff0_000f : 32'h0000_0073;
		endcase
		return ins;
	endfunction

	function automatic data_t alu_ref(input logic [2:0] f3, input logic alt,
			input data_t a, input data_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return data_t'($signed(a) < $signed(b));
			3'b011: return data_t'(a < b);
			3'b100: return a ^ b;
			3'b101: return alt ? data_t'($signed(a) >>> sh) : a >> sh;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "Stopping at the first mismatch.");
		end
	endtask

	task automatic drive_memories();
		instr_rdata = imem[instr_addr[9:2]];
		data_rdata  = dmem[data_addr[7:2]];
	endtask

	// Executes the instruction at the model PC and compares it with the retire.
	task automatic step_model();
		data_t ir;
		data_t rs1v;
		data_t rs2v;
		data_t imm_i;
		data_t wd;
		data_t next_pc;
		data_t addr;
		logic  writes;
		logic  is_mem;
		logic  taken;
		ir      = imem[m_pc[9:2]];
		rs1v    = m_regs[ir[19:15]];
		rs2v    = m_regs[ir[24:20]];
		imm_i   = data_t'($signed(ir[31:20]));
		wd      = NULL;
		next_pc = m_pc + 4;
		writes  = 1'b1;
		is_mem  = 1'b0;
		check_equal(retire_pc, m_pc, "retire_pc");
		case (opcode_t'(ir[6:0]))
			R: wd = alu_ref(ir[14:12], ir[30], rs1v, rs2v);
			I: wd = alu_ref(ir[14:12], ir[30] && ir[14:12] == 3'b101, rs1v, imm_i);
			LUI: wd = {ir[31:12], 12'h000};
			AUIPC: wd = m_pc + {ir[31:12], 12'h000};
			JAL: begin
				wd      = m_pc + 4;
				next_pc = m_pc + data_t'($signed({ir[31], ir[19:12], ir[20], ir[30:21], 1'b0}));
			end
			JALR: begin
				wd         = m_pc + 4;
				next_pc    = rs1v + imm_i;
				next_pc[0] = 1'b0;
			end
			B: begin
				writes = 1'b0;
				case (ir[14:12])
					3'b000: taken = rs1v == rs2v;
					3'b001: taken = rs1v != rs2v;
					3'b100: taken = $signed(rs1v) < $signed(rs2v);
					3'b101: taken = !($signed(rs1v) < $signed(rs2v));
					3'b110: taken = rs1v < rs2v;
					default: taken = !(rs1v < rs2v);
				endcase
				if (taken) begin
					next_pc = m_pc +
						data_t'($signed({ir[31], ir[7], ir[30:25], ir[11:8], 1'b0}));
				end
			end
			LOAD: begin
				is_mem = 1'b1;
				addr   = rs1v + imm_i;
				wd     = m_dmem[addr[7:2]];
				check_equal(load_seen, 1'b1, "data_re during load");
				check_equal(store_seen, 1'b0, "data_we during load");
			end
			STORE: begin
				writes = 1'b0;
				is_mem = 1'b1;
				addr   = rs1v + data_t'($signed({ir[31:25], ir[11:7]}));
				check_equal(store_seen, 1'b1, "data_we during store");
				check_equal(load_seen, 1'b0, "data_re during store");
				check_equal(st_addr, addr, "store address");
				check_equal(st_data, rs2v, "store data");
				m_dmem[addr[7:2]] = rs2v;
			end
			default: writes = 1'b0; // FENCE and SYSTEM only advance the PC.
		endcase
		if (!is_mem) begin
			check_equal(store_seen, 1'b0, "data_we outside a store");
			check_equal(load_seen, 1'b0, "data_re outside a load");
		end
		check_equal(retire_rd, writes ? ir[11:7] : 5'd0, "retire_rd");
		check_equal(retire_data, writes ? wd : NULL, "retire_data");
		if (retired > 0) begin
			check_equal(cycle_count - last_retire, is_mem ? 4 : 3, "cycles between retires");
		end
		if (writes && ir[11:7] != 5'd0) m_regs[ir[11:7]] = wd;
		m_pc       = next_pc;
		store_seen = 1'b0;
		load_seen  = 1'b0;
	endtask

	always @(posedge clk) begin
		if (arst_n) begin
			cycle_count++;
			if (cycle_count >= MAX_CYCLES) begin
				$display("Timeout: only %0d of %0d instructions retired in %0d cycles.",
					retired, NUM_RETIRES, cycle_count);
				$display("Test failed");
				$fatal(1, "Run aborted by the cycle limit.");
			end
		end
	end

	initial begin
		lfsr        = SEED;
		arst_n      = 1'b0;
		instr_rdata = '0;
		data_rdata  = '0;
		store_seen  = 1'b0;
		load_seen   = 1'b0;
		st_addr     = '0;
		st_data     = '0;
		for (int i = 0; i < 256; i++) imem[i] = gen_instr();
		for (int i = 0; i < 64; i++) begin
			dmem[i]   = rand_bits(32);
			m_dmem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) m_regs[i] = '0;
		m_pc = RESET_PC;
		repeat (5) begin
			@(negedge clk);
			drive_memories();
			check_equal(retire, 1'b0, "retire in reset");
			check_equal(data_we, 1'b0, "data_we in reset");
			check_equal(data_re, 1'b0, "data_re in reset");
			check_equal(instr_addr, RESET_PC, "instr_addr in reset");
		end
		arst_n = 1'b1;
		while (retired < NUM_RETIRES) begin
			@(negedge clk);
			drive_memories();
			if (data_we) begin
				store_seen              = 1'b1;
				st_addr                 = data_addr;
				st_data                 = data_wdata;
				dmem[data_addr[7:2]] = data_wdata;
			end
			if (data_re) load_seen = 1'b1;
			if (retire) begin
				step_model();
				retired++;
				last_retire = cycle_count;
			end
		end
		$display("Test passed");
		$finish;
	end

endmodule : tb_core

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import defines::*; #(
	parameter data_t RESET_PC = '0
) (
	input  logic     clk,
	input  logic     arst_n,
	output data_t    instr_addr,
	input  data_t    instr_rdata,
	output data_t    data_addr,
	output data_t    data_wdata,
	input  data_t    data_rdata,
	output logic     data_we,
	output logic     data_re,
	output logic     retire,
	output data_t    retire_pc,
	output data_t    retire_data,
	output reg_idx_t retire_rd
);

	logic  fetch_en;
	logic  mem_en;
	logic  wb_en;
	data_t pc;
	data_t rs1_val;
	data_t rs2_val;
	data_t wb_data;
	logic  writes_rd;

	exec_if exu ();

	core_ctrl i_ctrl (
		.clk      (clk),
		.arst_n   (arst_n),
		.opcode   (exu.instr.opcode),
		.state    (),
		.fetch_en (fetch_en),
		.mem_en   (mem_en),
		.wb_en    (wb_en)
	);

	pc_reg #(.RESET_PC(RESET_PC)) i_pc (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_en  (wb_en),
		.pc     (pc),
		.exu    (exu.pc)
	);

	regfile i_rf (
		.clk    (clk),
		.arst_n (arst_n),
		.we     (wb_en & writes_rd),
		.waddr  (exu.instr.rd),
		.raddr1 (exu.instr.rs1),
		.raddr2 (exu.instr.rs2),
		.wdata  (wb_data),
		.rdata1 (rs1_val),
		.rdata2 (rs2_val)
	);

	execute i_exe (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_en    (fetch_en),
		.mem_en      (mem_en),
		.pc          (pc),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.instr_rdata (instr_rdata),
		.data_rdata  (data_rdata),
		.data_addr   (data_addr),
		.data_wdata  (data_wdata),
		.data_we     (data_we),
		.data_re     (data_re),
		.exu         (exu.ex)
	);

	wb i_wb (
		.exu       (exu.sink),
		.wb_data   (wb_data),
		.writes_rd (writes_rd)
	);

	assign instr_addr  = {pc[31:2], 2'b00}; // Fetches are word aligned.
	assign retire      = wb_en;
	assign retire_pc   = pc; // Still the retiring instruction's address in WRITEBACK.
	assign retire_data = wb_data;
	assign retire_rd   = writes_rd ? exu.instr.rd : '0;

endmodule : core_top

`default_nettype wire

//--- wb.sv
`timescale 1ns/1ps
`default_nettype none

module wb import defines::*; (
	exec_if.sink  exu,
	output data_t wb_data,
	output logic  writes_rd
);

	opcode_t opcode;

	assign opcode = exu.instr.opcode;

	always_comb begin : wb_sel
		unique case (opcode)
			R, I, LUI, AUIPC: begin
				wb_data   = exu.alu_result;
				writes_rd = 1'b1;
			end
			JAL, JALR: begin
				wb_data   = exu.pc_p4; // Link address.
				writes_rd = 1'b1;
			end
			LOAD: begin
				wb_data   = exu.mem_data;
				writes_rd = 1'b1;
			end
			B, STORE, MEM, SYS: begin
				wb_data   = NULL;
				writes_rd = 1'b0;
			end
			default: begin
				wb_data   = NULL;
				writes_rd = 1'b0;
			end
		endcase
	end

endmodule : wb

`default_nettype wire

//--- execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import defines::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  fetch_en,
	input  logic  mem_en,
	input  data_t pc,
	input  data_t rs1_val,
	input  data_t rs2_val,
	input  data_t instr_rdata,
	input  data_t data_rdata,
	output data_t data_addr,
	output data_t data_wdata,
	output logic  data_we,
	output logic  data_re,
	exec_if.ex    exu
);

	logic    ex_q; // High during the EXECUTE cycle that follows the fetch strobe.
	data_t   ir;
	opcode_t opcode;
	data_t   imm;
	data_t   op_a;
	data_t   op_b;
	alu_op_t alu_op;
	data_t   alu_out;
	logic    cond;
	data_t   tgt;

	assign ir     = exu.instr;
	assign opcode = exu.instr.opcode;

	always_comb begin
		unique case (opcode)
			I, JALR, LOAD: imm = {{20{ir[31]}}, ir[31:20]};
			STORE:         imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			B:             imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			LUI, AUIPC:    imm = {ir[31:12], 12'b0};
			JAL:           imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default:       imm = '0;
		endcase
	end

	assign op_a = (opcode == AUIPC) ? pc : rs1_val;
	assign op_b = (opcode == R || opcode == B) ? rs2_val : imm;

	always_comb begin
		alu_op = ALU_ADD; // Address generation and AUIPC add.
		if (opcode == LUI) begin
			alu_op = ALU_PASS_B;
		end else if (opcode == R || opcode == I) begin
			case (exu.instr.funct3)
				3'b000: alu_op = (opcode == R && ir[30]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_SLT;
				3'b011: alu_op = ALU_SLTU;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = ir[30] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << op_b[4:0];
			ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> op_b[4:0];
			ALU_SRA:    alu_out = data_t'($signed(op_a) >>> op_b[4:0]);
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = op_a + op_b;
		endcase
	end

	always_comb begin
		case (exu.instr.funct3)
			3'b000:  cond = (rs1_val == rs2_val);
			3'b001:  cond = (rs1_val != rs2_val);
			3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
			3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
			3'b110:  cond = (rs1_val < rs2_val);
			3'b111:  cond = (rs1_val >= rs2_val);
			default: cond = 1'b0;
		endcase
	end

	assign tgt = (opcode == JALR) ? ((rs1_val + imm) & ~32'd1) : (pc + imm);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_q <= 1'b0;
		end else begin
			ex_q <= fetch_en;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_en) exu.instr <= instr_t'(instr_rdata);
		if (ex_q) begin
			exu.alu_result   <= alu_out;
			exu.branch_taken <= (opcode == B && cond) || opcode == JAL || opcode == JALR;
			exu.target       <= tgt;
		end
		if (data_re) exu.mem_data <= data_rdata;
	end

	assign data_addr  = exu.alu_result;
	assign data_wdata = rs2_val;
	assign data_re    = mem_en && opcode == LOAD;
	assign data_we    = mem_en && opcode == STORE;

endmodule : execute

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import defines::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     we,
	input  reg_idx_t waddr,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	input  data_t    wdata,
	output data_t    rdata1,
	output data_t    rdata2
);

	data_t regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin // Entry 0 is never written.
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// x0 keeps reading zero even right after an instruction targets it.
	x0_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
		(we && waddr == '0) |=>
			(raddr1 != '0 || rdata1 == NULL) && (raddr2 != '0 || rdata2 == NULL));

endmodule : regfile

`default_nettype wire

//--- pc_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pc_reg import defines::*; #(
	parameter data_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  wb_en,
	output data_t pc,
	exec_if.pc    exu
);

	assign exu.pc_p4 = pc + 32'd4; // Also the link value for JAL and JALR.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (wb_en) begin
			if (exu.branch_taken) begin
				pc <= exu.target;
			end else begin
				pc <= exu.pc_p4;
			end
		end
	end

	// The PC only moves when an instruction retires.
	pc_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		!wb_en |=> $stable(pc));

endmodule : pc_reg

`default_nettype wire

//--- core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import defines::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  opcode_t     opcode,
	output core_state_t state,
	output logic        fetch_en,
	output logic        mem_en,
	output logic        wb_en
);

	core_state_t state_next;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		unique case (state)
			FETCH: begin
				state_next = EXECUTE;
			end
			EXECUTE: begin
				// Only word loads and stores need the data port.
				if (opcode == LOAD || opcode == STORE) begin
					state_next = MEMORY;
				end else begin
					state_next = WRITEBACK;
				end
			end
			MEMORY: begin
				state_next = WRITEBACK;
			end
			WRITEBACK: begin
				state_next = FETCH;
			end
			default: begin
				state_next = FETCH;
			end
		endcase
	end

	assign fetch_en = (state == FETCH);
	assign mem_en   = (state == MEMORY);
	assign wb_en    = (state == WRITEBACK);

	// Writeback follows MEMORY for loads and stores and EXECUTE for every other opcode.
	wb_step_a: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> (opcode inside {LOAD, STORE} ? $past(mem_en) : $past(state) == EXECUTE));

	mem_step_a: assert property (@(posedge clk) disable iff (!arst_n)
		state == MEMORY |-> $past(state) == EXECUTE && opcode inside {LOAD, STORE});

endmodule : core_ctrl

`default_nettype wire

//--- exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_if import defines::*; ();

	instr_t instr;
	data_t  alu_result;
	data_t  mem_data;
	data_t  pc_p4;
	logic   branch_taken;
	data_t  target;

	modport ex (
		output instr, alu_result, mem_data, branch_taken, target
	);

	modport pc (
		input  branch_taken, target,
		output pc_p4
	);

	modport sink (
		input instr, alu_result, mem_data, pc_p4
	);

endinterface : exec_if

`default_nettype wire

//--- defines.sv
`default_nettype none

package defines;

	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_idx_t;

	// RV32I major opcodes.
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111, // FENCE.
		SYS   = 7'b1110011
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // Used by LUI.
	} alu_op_t;

	// One instruction walks through these steps in order.
	typedef enum logic [1:0] {
		FETCH,
		EXECUTE,
		MEMORY,
		WRITEBACK
	} core_state_t;

	localparam data_t NULL = '0; // Writeback value when no register is written.

endpackage : defines

`default_nettype wire
